// ==== pipeCpu.f ====
+incdir+include
hw/mipsIsaPkg.sv
hw/pipeCtrlPkg.sv
hw/registerFile.sv
hw/instDecode.sv
hw/hazardUnit.sv
hw/execute.sv
hw/resultStage.sv
hw/pipeCpu.sv
sim/tbPipeCpu.sv

// ==== include/cpuRefModel.svh ====
// ----------------------------------------
// Reference model for the CPU testbench
// Random program generator and an
// in-order interpreter that records
// every load and store
// ----------------------------------------

`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

localparam int PROG_WORDS = 128;
localparam int RAM_WORDS  = 64;
localparam int RAND_LEN   = 48;
// First of the seven register dump stores
localparam int DUMP_AT    = 7 + RAND_LEN;
localparam int HALT_AT    = DUMP_AT + 7;

int          seed = 75952;
logic [31:0] prog [PROG_WORDS];
logic [31:0] refRam [RAM_WORDS];
logic [31:0] refRegs [32];
logic [31:0] expStAddr [$];
logic [31:0] expStData [$];
logic [31:0] expLdAddr [$];

// Initial data RAM contents
function automatic logic [31:0] ramFill(int idx);
    return 32'hc0de_0000 + idx * 32'h0103_0507;
endfunction

function automatic int randBelow(int n);
    return int'($unsigned($random(seed)) % n);
endfunction

function automatic logic [31:0] encR(functE fn, int rs, int rt, int rd);
    return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'h00, fn};
endfunction

function automatic logic [31:0] encI(opcodeE op, int rs, int rt, logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
endfunction

task automatic buildProgram();
    int          i;
    int          ra;
    int          rb;
    int          rc;
    int          tgt;
    logic [15:0] imm;
    logic [15:0] offset;
    for (i = 0; i < PROG_WORDS; i++) begin
        prog[i] = '0;
    end
    // Seed registers 1 to 7
    for (i = 1; i < 8; i++) begin
        prog[i-1] = encI(OP_ADDIU, 0, i, 16'(randBelow(65536)));
    end
    for (i = 7; i < DUMP_AT; i++) begin
        ra     = 1 + randBelow(7);
        rb     = 1 + randBelow(7);
        rc     = 1 + randBelow(7);
        imm    = 16'(randBelow(65536));
        offset = 16'(4 * randBelow(RAM_WORDS));
        tgt    = i + 1 + randBelow(DUMP_AT - i);
        // Equal operands now and then so beq gets taken
        if (randBelow(3) == 0) begin
            rb = ra;
        end
        case (randBelow(13))
            0:       prog[i] = encR(FN_ADDU, ra, rb, rc);
            1:       prog[i] = encR(FN_SUBU, ra, rb, rc);
            2:       prog[i] = encR(FN_AND, ra, rb, rc);
            3:       prog[i] = encR(FN_OR, ra, rb, rc);
            4:       prog[i] = encR(FN_SLT, ra, rb, rc);
            5:       prog[i] = encI(OP_ADDIU, ra, rb, imm);
            6:       prog[i] = encI(OP_ORI, ra, rb, imm);
            7:       prog[i] = encI(OP_LUI, 0, rb, imm);
            8:       prog[i] = encI(OP_LW, 0, rb, offset);
            9:       prog[i] = encI(OP_SW, 0, rb, offset);
            10:      prog[i] = encI(OP_BEQ, ra, rb, 16'(tgt - i - 1));
            11:      prog[i] = encI(OP_BNE, ra, rb, 16'(tgt - i - 1));
            default: prog[i] = {OP_J, 26'(tgt)};
        endcase
    end
    for (i = 1; i < 8; i++) begin
        prog[DUMP_AT+i-1] = encI(OP_SW, 0, i, 16'(128 + 4 * i));
    end
    prog[HALT_AT] = {OP_J, 26'(HALT_AT)};
endtask

task automatic runModel();
    int          idx;
    int          nextIdx;
    int          steps;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sImm;
    logic [31:0] addr;
    for (idx = 0; idx < RAM_WORDS; idx++) begin
        refRam[idx] = ramFill(idx);
    end
    for (idx = 0; idx < 32; idx++) begin
        refRegs[idx] = '0;
    end
    idx   = 0;
    steps = 0;
    while (idx != HALT_AT && steps < 1000) begin
        w       = prog[idx];
        a       = refRegs[w[25:21]];
        b       = refRegs[w[20:16]];
        sImm    = {{16{w[15]}}, w[15:0]};
        addr    = a + sImm;
        nextIdx = idx + 1;
        case (w[31:26])
            OP_RTYPE: begin
                case (w[5:0])
                    FN_ADDU: refRegs[w[15:11]] = a + b;
                    FN_SUBU: refRegs[w[15:11]] = a - b;
                    FN_AND:  refRegs[w[15:11]] = a & b;
                    FN_OR:   refRegs[w[15:11]] = a | b;
                    FN_SLT:  refRegs[w[15:11]] = {31'b0, $signed(a) < $signed(b)};
                    default: ;
                endcase
            end
            OP_ADDIU: refRegs[w[20:16]] = addr;
            OP_ORI:   refRegs[w[20:16]] = a | {16'h0, w[15:0]};
            OP_LUI:   refRegs[w[20:16]] = {w[15:0], 16'h0};
            OP_LW: begin
                refRegs[w[20:16]] = refRam[addr[7:2]];
                expLdAddr.push_back(addr);
            end
            OP_SW: begin
                refRam[addr[7:2]] = b;
                expStAddr.push_back(addr);
                expStData.push_back(b);
            end
            OP_BEQ: nextIdx = (a == b) ? idx + 1 + int'(w[15:0]) : nextIdx;
            OP_BNE: nextIdx = (a != b) ? idx + 1 + int'(w[15:0]) : nextIdx;
            OP_J:   nextIdx = int'(w[25:0]);
            default: ;
        endcase
        refRegs[0] = '0;
        idx        = nextIdx;
        steps++;
    end
endtask

`endif

// ==== sim/tbPipeCpu.sv ====
// ----------------------------------------
// Testbench for the pipelined MIPS CPU
// Runs a random program and checks every
// load and store against the model
// ----------------------------------------

`timescale 1ns/1ps

module tbPipeCpu;
    import mipsIsaPkg::*;

    `include "cpuRefModel.svh"

    localparam int RUN_LIMIT = 2000;

    logic        clk;
    logic        rstN;
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] dataAddress;
    logic [31:0] writeMemData;
    logic        memRead;
    logic        memWrite;
    logic [31:0] readMemData;
    logic [31:0] dataRam [RAM_WORDS];
    int          stIdx;
    int          ldIdx;

    pipeCpu i_pipeCpu (
        .clk          (clk),
        .rstN         (rstN),
        .pc           (pc),
        .inst         (inst),
        .dataAddress  (dataAddress),
        .writeMemData (writeMemData),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .readMemData  (readMemData)
    );

    always #2 clk = ~clk;

    // ------------------------------------
    // Failure reporting
    // ------------------------------------
    task automatic stopOnFailure();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic failRun(string msg);
        $display("Error: %s", msg);
        stopOnFailure();
    endtask

    task automatic checkEq(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            stopOnFailure();
        end
    endtask

    task automatic checkReset();
        checkEq("pc", RESET_PC, pc);
        checkEq("memRead", 32'h0, memRead);
        checkEq("memWrite", 32'h0, memWrite);
    endtask

    // ------------------------------------
    // Memories
    // ------------------------------------
    // ROM and RAM read data driven 1 ns after each rising edge
    always @(posedge clk) begin
        #1;
        inst        = prog[pc[8:2]];
        readMemData = dataRam[dataAddress[7:2]];
    end

    // Stores commit here ahead of the next read
    always @(negedge clk) begin
        if (rstN && memWrite) begin
            if (stIdx >= expStAddr.size()) begin
                failRun("store seen after the last store of the model");
            end else begin
                checkEq("dataAddress", expStAddr[stIdx], dataAddress);
                checkEq("writeMemData", expStData[stIdx], writeMemData);
                dataRam[dataAddress[7:2]] = writeMemData;
                stIdx++;
            end
        end
        if (rstN && memRead) begin
            if (ldIdx >= expLdAddr.size()) begin
                failRun("load seen after the last load of the model");
            end else begin
                checkEq("dataAddress", expLdAddr[ldIdx], dataAddress);
                ldIdx++;
            end
        end
    end

    // ------------------------------------
    // Main sequence
    // ------------------------------------
    initial begin
        int i;
        int cycles;
        clk         = 1'b0;
        rstN        = 1'b0;
        inst        = '0;
        readMemData = '0;
        stIdx       = 0;
        ldIdx       = 0;
        buildProgram();
        runModel();
        for (i = 0; i < RAM_WORDS; i++) begin
            dataRam[i] = ramFill(i);
        end

        repeat (8) begin
            @(negedge clk);
            checkReset();
        end
        @(posedge clk);
        #1;
        rstN = 1'b1;
        @(negedge clk);
        checkReset();

        // Ends when the register dump has been stored
        cycles = 0;
        while (stIdx < expStAddr.size() && cycles < RUN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end

        if (stIdx < expStAddr.size()) begin
            failRun("program did not finish, register dump stores missing");
        end else begin
            checkEq("load count", 32'(expLdAddr.size()), 32'(ldIdx));
            $display("%0d stores and %0d loads checked in %0d cycles",
                     stIdx, ldIdx, cycles);
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// ==== hw/pipeCpu.sv ====
// -------------------------------------
// Five-stage pipelined MIPS subset CPU
// Holds the PC and wires the stages to
// external instruction and data memory
// -------------------------------------

`timescale 1ns/1ps

module pipeCpu (
    input  logic                          clk,
    input  logic                          rstN,
    output logic [mipsIsaPkg::WORD_W-1:0] pc,
    input  logic [mipsIsaPkg::WORD_W-1:0] inst,
    output logic [mipsIsaPkg::WORD_W-1:0] dataAddress,
    output logic [mipsIsaPkg::WORD_W-1:0] writeMemData,
    output logic                          memRead,
    output logic                          memWrite,
    input  logic [mipsIsaPkg::WORD_W-1:0] readMemData
);
    import mipsIsaPkg::*;
    import pipeCtrlPkg::*;

    logic [WORD_W-1:0] pcPlus4;
    logic [WORD_W-1:0] target;
    logic              taken;
    logic              stall;
    logic [REG_W-1:0]  readReg1;
    logic [REG_W-1:0]  readReg2;
    logic [WORD_W-1:0] readData1;
    logic [WORD_W-1:0] readData2;
    logic [REG_W-1:0]  idRs;
    logic [REG_W-1:0]  idRt;
    logic              idLoadUse;
    decodeT            decoded;
    fwdSelE            rsSel;
    fwdSelE            rtSel;
    memT               memStage;
    wbT                wbView;
    logic [REG_W-1:0]  wbWriteReg;
    logic [WORD_W-1:0] wbWriteData;
    logic              wbRegWrite;

    // ------------------ Fetch ------------------
    assign pcPlus4 = pc + WORD_W'(4);

    // Redirect wins over a load-use hold
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= RESET_PC;
        end else if (taken) begin
            pc <= target;
        end else if (!stall) begin
            pc <= pcPlus4;
        end
    end

    // ------------------ Stages -----------------
    registerFile u_registerFile (
        .clk       (clk),
        .rstN      (rstN),
        .readReg1  (readReg1),
        .readReg2  (readReg2),
        .writeReg  (wbWriteReg),
        .writeData (wbWriteData),
        .regWrite  (wbRegWrite),
        .readData1 (readData1),
        .readData2 (readData2)
    );

    instDecode u_instDecode (
        .clk       (clk),
        .rstN      (rstN),
        .inst      (inst),
        .pcPlus4   (pcPlus4),
        .stall     (stall),
        .flush     (taken),
        .readReg1  (readReg1),
        .readReg2  (readReg2),
        .readData1 (readData1),
        .readData2 (readData2),
        .idRs      (idRs),
        .idRt      (idRt),
        .idLoadUse (idLoadUse),
        .decoded   (decoded)
    );

    // Write-back view for forwarding
    assign wbView = '{valid: wbRegWrite, aluOut: wbWriteData, loadData: wbWriteData,
                      memRead: 1'b0, writeReg: wbWriteReg, regWrite: wbRegWrite};

    hazardUnit u_hazardUnit (
        .decoded  (decoded),
        .idRs     (idRs),
        .idRt     (idRt),
        .memStage (memStage),
        .wbStage  (wbView),
        .rsSel    (rsSel),
        .rtSel    (rtSel),
        .stall    (stall)
    );

    execute u_execute (
        .clk      (clk),
        .rstN     (rstN),
        .decoded  (decoded),
        .rsSel    (rsSel),
        .rtSel    (rtSel),
        .memFwd   (memStage.aluOut),
        .wbFwd    (wbWriteData),
        .taken    (taken),
        .target   (target),
        .memStage (memStage)
    );

    // ------------------ Memory -----------------
    assign dataAddress  = memStage.aluOut;
    assign writeMemData = memStage.storeData;
    assign memRead      = memStage.memRead;
    assign memWrite     = memStage.memWrite;

    resultStage u_resultStage (
        .clk         (clk),
        .rstN        (rstN),
        .memStage    (memStage),
        .readMemData (readMemData),
        .writeReg    (wbWriteReg),
        .writeData   (wbWriteData),
        .regWrite    (wbRegWrite)
    );

    // A load-use hold bubbles decode but the load itself still reaches memory
    loadReachesMemory: assert property (@(posedge clk) disable iff (!rstN)
        idLoadUse |=> memRead);

endmodule

// ==== hw/resultStage.sv ====
// -------------------------------------
// Result stage
// MEM/WB register and write-back select
// -------------------------------------

`timescale 1ns/1ps

module resultStage (
    input  logic                          clk,
    input  logic                          rstN,
    input  pipeCtrlPkg::memT              memStage,
    input  logic [mipsIsaPkg::WORD_W-1:0] readMemData,
    output logic [mipsIsaPkg::REG_W-1:0]  writeReg,
    output logic [mipsIsaPkg::WORD_W-1:0] writeData,
    output logic                          regWrite
);
    import pipeCtrlPkg::*;

    wbT wbStage;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbStage <= '0;
        end else begin
            wbStage.valid    <= memStage.valid;
            wbStage.aluOut   <= memStage.aluOut;
            wbStage.loadData <= readMemData;
            wbStage.memRead  <= memStage.memRead;
            wbStage.writeReg <= memStage.writeReg;
            wbStage.regWrite <= memStage.regWrite;
        end
    end

    // Loads return memory data, everything else the ALU result
    assign writeData = wbStage.memRead ? wbStage.loadData : wbStage.aluOut;
    assign writeReg  = wbStage.writeReg;
    assign regWrite  = wbStage.valid && wbStage.regWrite;

endmodule

// ==== hw/execute.sv ====
// -------------------------------------
// Execute stage
// Operand forwarding, ALU, branch and
// jump resolution, EX/MEM register
// -------------------------------------

`timescale 1ns/1ps

module execute (
    input  logic                          clk,
    input  logic                          rstN,
    input  pipeCtrlPkg::decodeT           decoded,
    input  pipeCtrlPkg::fwdSelE           rsSel,
    input  pipeCtrlPkg::fwdSelE           rtSel,
    input  logic [mipsIsaPkg::WORD_W-1:0] memFwd,
    input  logic [mipsIsaPkg::WORD_W-1:0] wbFwd,
    output logic                          taken,
    output logic [mipsIsaPkg::WORD_W-1:0] target,
    output pipeCtrlPkg::memT              memStage
);
    import mipsIsaPkg::*;
    import pipeCtrlPkg::*;

    logic [WORD_W-1:0] rsVal;
    logic [WORD_W-1:0] rtVal;
    logic [WORD_W-1:0] opB;
    logic [WORD_W-1:0] aluOut;
    logic              equal;

    function automatic logic [WORD_W-1:0] pickOperand(fwdSelE sel,
                                                      logic [WORD_W-1:0] regVal,
                                                      logic [WORD_W-1:0] memVal,
                                                      logic [WORD_W-1:0] wbVal);
        case (sel)
            FWD_FROM_MEM: return memVal;
            FWD_FROM_WB:  return wbVal;
            default:      return regVal;
        endcase
    endfunction

    assign rsVal = pickOperand(rsSel, decoded.rsData, memFwd, wbFwd);
    assign rtVal = pickOperand(rtSel, decoded.rtData, memFwd, wbFwd);
    assign opB   = decoded.useImm ? decoded.imm : rtVal;

    // ------------------ ALU --------------------
    always_comb begin
        case (decoded.aluOp)
            ALU_SUB: aluOut = rsVal - opB;
            ALU_AND: aluOut = rsVal & opB;
            ALU_OR:  aluOut = rsVal | opB;
            ALU_SLT: aluOut = {{(WORD_W-1){1'b0}}, $signed(rsVal) < $signed(opB)};
            ALU_LUI: aluOut = {opB[15:0], {(WORD_W-16){1'b0}}};
            default: aluOut = rsVal + opB;
        endcase
    end

    // Branch compare uses forwarded values
    assign equal  = (rsVal == rtVal);
    assign taken  = decoded.valid
                    && (decoded.isJump || (decoded.isBranch && (equal ^ decoded.branchNe)));
    assign target = decoded.isJump ? decoded.jumpTarget
                    : decoded.pcPlus4 + {decoded.imm[WORD_W-3:0], 2'b00};

    // ------------------ EX/MEM -----------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memStage <= '0;
        end else begin
            memStage.valid     <= decoded.valid;
            memStage.aluOut    <= aluOut;
            memStage.storeData <= rtVal;
            memStage.writeReg  <= decoded.writeReg;
            memStage.regWrite  <= decoded.valid && decoded.regWrite;
            memStage.memRead   <= decoded.valid && decoded.memRead;
            memStage.memWrite  <= decoded.valid && decoded.memWrite;
        end
    end

    // A redirect comes from a real control op and kills the next ID/EX slot
    takenFlushes: assert property (@(posedge clk) disable iff (!rstN)
        taken |-> (decoded.valid && (decoded.isBranch || decoded.isJump))
                  ##1 !decoded.valid);

endmodule

// ==== hw/hazardUnit.sv ====
// -------------------------------------
// Hazard unit
// Forwarding selection per operand and
// load-use stall detection
// -------------------------------------

`timescale 1ns/1ps

module hazardUnit (
    input  pipeCtrlPkg::decodeT          decoded,
    input  logic [mipsIsaPkg::REG_W-1:0] idRs,
    input  logic [mipsIsaPkg::REG_W-1:0] idRt,
    input  pipeCtrlPkg::memT             memStage,
    input  pipeCtrlPkg::wbT              wbStage,
    output pipeCtrlPkg::fwdSelE          rsSel,
    output pipeCtrlPkg::fwdSelE          rtSel,
    output logic                         stall
);
    import mipsIsaPkg::*;
    import pipeCtrlPkg::*;

    logic loadInEx;

    // Memory stage is younger, so it overrides write-back
    function automatic fwdSelE pickSource(logic [REG_W-1:0] src, memT m, wbT w);
        fwdSelE sel;
        sel = FWD_NONE;
        if (src != '0 && w.valid && w.regWrite && w.writeReg == src) begin
            sel = FWD_FROM_WB;
        end
        if (src != '0 && m.valid && m.regWrite && m.writeReg == src) begin
            sel = FWD_FROM_MEM;
        end
        return sel;
    endfunction

    assign rsSel = pickSource(decoded.rs, memStage, wbStage);
    assign rtSel = pickSource(decoded.rt, memStage, wbStage);

    assign loadInEx = decoded.valid && decoded.memRead && decoded.regWrite;
    assign stall = loadInEx && decoded.writeReg != '0
                   && (decoded.writeReg == idRs || decoded.writeReg == idRt);

    // Load data is not ready yet in MEM
    always_comb begin
        noLoadFwd: assert final (!(memStage.memRead
            && (rsSel == FWD_FROM_MEM || rtSel == FWD_FROM_MEM)));
    end

endmodule

// ==== hw/instDecode.sv ====
// -------------------------------------
// Decode stage
// IF/ID register, control decode and
// the ID/EX payload register
// -------------------------------------

`timescale 1ns/1ps

module instDecode (
    input  logic                          clk,
    input  logic                          rstN,
    input  mipsIsaPkg::instT              inst,
    input  logic [mipsIsaPkg::WORD_W-1:0] pcPlus4,
    input  logic                          stall,
    input  logic                          flush,
    output logic [mipsIsaPkg::REG_W-1:0]  readReg1,
    output logic [mipsIsaPkg::REG_W-1:0]  readReg2,
    input  logic [mipsIsaPkg::WORD_W-1:0] readData1,
    input  logic [mipsIsaPkg::WORD_W-1:0] readData2,
    output logic [mipsIsaPkg::REG_W-1:0]  idRs,
    output logic [mipsIsaPkg::REG_W-1:0]  idRt,
    output logic                          idLoadUse,
    output pipeCtrlPkg::decodeT           decoded
);
    import mipsIsaPkg::*;
    import pipeCtrlPkg::*;

    instT              ifInst;
    logic [WORD_W-1:0] ifPcPlus4;
    logic              ifValid;
    decodeT            dec;
    logic              known;
    logic              readsRs;
    logic              readsRt;

    // ------------------ IF/ID ------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ifValid   <= 1'b0;
            ifInst    <= '0;
            ifPcPlus4 <= '0;
        end else if (flush) begin
            ifValid <= 1'b0;
        end else if (!stall) begin
            ifValid   <= 1'b1;
            ifInst    <= inst;
            ifPcPlus4 <= pcPlus4;
        end
    end

    assign readReg1 = ifInst.rs;
    assign readReg2 = ifInst.rt;

    // ------------------ Decode -----------------
    always_comb begin
        dec          = '0;
        known        = 1'b1;
        readsRs      = 1'b1;
        readsRt      = 1'b0;
        dec.aluOp    = ALU_ADD;
        dec.writeReg = ifInst.rt;
        dec.imm      = {{(WORD_W-16){ifInst[15]}}, ifInst[15:0]};
        case (ifInst.opcode)
            OP_RTYPE: begin
                readsRt      = 1'b1;
                dec.regWrite = 1'b1;
                dec.writeReg = ifInst.rd;
                case (ifInst.funct)
                    FN_ADDU: dec.aluOp = ALU_ADD;
                    FN_SUBU: dec.aluOp = ALU_SUB;
                    FN_AND:  dec.aluOp = ALU_AND;
                    FN_OR:   dec.aluOp = ALU_OR;
                    FN_SLT:  dec.aluOp = ALU_SLT;
                    default: known = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                dec.useImm   = 1'b1;
                dec.regWrite = 1'b1;
            end
            OP_ORI: begin
                dec.aluOp    = ALU_OR;
                dec.useImm   = 1'b1;
                dec.regWrite = 1'b1;
                dec.imm      = {{(WORD_W-16){1'b0}}, ifInst[15:0]};
            end
            OP_LUI: begin
                readsRs      = 1'b0;
                dec.aluOp    = ALU_LUI;
                dec.useImm   = 1'b1;
                dec.regWrite = 1'b1;
            end
            OP_LW: begin
                dec.useImm   = 1'b1;
                dec.memRead  = 1'b1;
                dec.regWrite = 1'b1;
            end
            OP_SW: begin
                readsRt      = 1'b1;
                dec.useImm   = 1'b1;
                dec.memWrite = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                readsRt      = 1'b1;
                dec.isBranch = 1'b1;
                dec.branchNe = (ifInst.opcode == OP_BNE);
            end
            OP_J: begin
                readsRs    = 1'b0;
                dec.isJump = 1'b1;
            end
            default: known = 1'b0;
        endcase

        // Only registers actually read take part in hazards
        idRs = (ifValid && known && readsRs) ? ifInst.rs : '0;
        idRt = (ifValid && known && readsRt) ? ifInst.rt : '0;

        dec.valid      = ifValid && known;
        dec.regWrite   = dec.regWrite && (dec.writeReg != '0);
        dec.pcPlus4    = ifPcPlus4;
        dec.rs         = idRs;
        dec.rt         = idRt;
        dec.rsData     = readData1;
        dec.rtData     = readData2;
        dec.jumpTarget = {ifPcPlus4[WORD_W-1:28], ifInst[25:0], 2'b00};
        if (!dec.valid) begin
            dec = '0;
        end
    end

    // ------------------ ID/EX ------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decoded <= '0;
        end else if (stall || flush) begin
            decoded <= '0;
        end else begin
            decoded <= dec;
        end
    end

    assign idLoadUse = decoded.valid && decoded.memRead;

endmodule

// ==== hw/registerFile.sv ====
// -------------------------------------
// 32 x 32 register file, 2R1W
// Writes bypass to same-cycle reads
// -------------------------------------

`timescale 1ns/1ps

module registerFile (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic [mipsIsaPkg::REG_W-1:0]  readReg1,
    input  logic [mipsIsaPkg::REG_W-1:0]  readReg2,
    input  logic [mipsIsaPkg::REG_W-1:0]  writeReg,
    input  logic [mipsIsaPkg::WORD_W-1:0] writeData,
    input  logic                          regWrite,
    output logic [mipsIsaPkg::WORD_W-1:0] readData1,
    output logic [mipsIsaPkg::WORD_W-1:0] readData2
);
    import mipsIsaPkg::*;

    logic [WORD_W-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (regWrite && writeReg != '0) begin
            regs[writeReg] <= writeData;
        end
    end

    function automatic logic [WORD_W-1:0] readPort(logic [REG_W-1:0] idx,
                                                   logic [WORD_W-1:0] stored);
        if (idx == '0) begin
            return '0;
        end
        return (regWrite && writeReg == idx) ? writeData : stored;
    endfunction

    always_comb begin
        readData1 = readPort(readReg1, regs[readReg1]);
    end

    always_comb begin
        readData2 = readPort(readReg2, regs[readReg2]);
    end

    // Decode masks writes to $0
    noZeroWrite: assert property (@(posedge clk) disable iff (!rstN)
        regWrite |-> writeReg != '0);

endmodule

// ==== hw/pipeCtrlPkg.sv ====
// -------------------------------------
// Pipeline internal types
// ALU operations, forwarding selects
// and the stage payload registers
// -------------------------------------

package pipeCtrlPkg;

    import mipsIsaPkg::*;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } aluOpE;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_FROM_MEM,
        FWD_FROM_WB
    } fwdSelE;

    // ID/EX payload
    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] pcPlus4;
        logic [REG_W-1:0]  rs;
        logic [REG_W-1:0]  rt;
        logic [WORD_W-1:0] rsData;
        logic [WORD_W-1:0] rtData;
        logic [WORD_W-1:0] imm;
        logic [WORD_W-1:0] jumpTarget;
        aluOpE             aluOp;
        logic              useImm;
        logic              memRead;
        logic              memWrite;
        logic              isBranch;
        logic              branchNe;
        logic              isJump;
        logic [REG_W-1:0]  writeReg;
        logic              regWrite;
    } decodeT;

    // EX/MEM payload
    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] aluOut;
        logic [WORD_W-1:0] storeData;
        logic [REG_W-1:0]  writeReg;
        logic              regWrite;
        logic              memRead;
        logic              memWrite;
    } memT;

    // MEM/WB payload
    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] aluOut;
        logic [WORD_W-1:0] loadData;
        logic              memRead;
        logic [REG_W-1:0]  writeReg;
        logic              regWrite;
    } wbT;

endpackage

// ==== hw/mipsIsaPkg.sv ====
// -------------------------------------
// MIPS subset instruction encoding
// Word widths, opcode and funct codes
// and the instruction field layout
// -------------------------------------

package mipsIsaPkg;

    localparam int WORD_W = 32;
    localparam int REG_W = 5;
    localparam logic [WORD_W-1:0] RESET_PC = '0;

    // Primary opcodes
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcodeE;

    // R-type funct codes
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } functE;

    // Immediate is bits 15:0, jump target bits 25:0
    typedef struct packed {
        opcodeE           opcode;
        logic [REG_W-1:0] rs;
        logic [REG_W-1:0] rt;
        logic [REG_W-1:0] rd;
        logic [4:0]       shamt;
        functE            funct;
    } instT;

endpackage
